// ==== include/r5p_bus_defines.svh ====
////////////////////////////////////////////////////////////
// r5p system bus parameters
// bus widths, device count, memory size and address map
////////////////////////////////////////////////////////////

`ifndef R5P_BUS_DEFINES_SVH
`define R5P_BUS_DEFINES_SVH

// bus widths
`define R5P_AW 32  // address width
`define R5P_DW 32  // data width, byte select is DW/8

// interconnect
`define R5P_BN 2   // devices behind the decoder

////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////

// memory window 4 KiB, only 1 KiB populated, wraps
`define R5P_MEM_AS 32'h0000_0xxx
// gpio window, 256 bytes
`define R5P_GPIO_AS 32'h0001_00xx

// memory size in words
`define R5P_MEM_DEPTH 256

`endif

// ==== hw/r5p_bus_pkg.sv ====
////////////////////////////////////////////////////////////
// r5p system bus types and gpio register map
////////////////////////////////////////////////////////////

`include "r5p_bus_defines.svh"

package r5p_bus_pkg;

  // bus field vectors
  typedef logic [`R5P_AW-1:0]   r5p_adr_t;  // address
  typedef logic [`R5P_DW-1:0]   r5p_dat_t;  // read/write data
  typedef logic [`R5P_DW/8-1:0] r5p_sel_t;  // byte select

  // gpio register offsets inside the 256 byte window
  // other offsets read zero, writes dropped
  typedef enum logic [7:0] {
    GPIO_OUT = 8'h00,  // output register, rw
    GPIO_IN  = 8'h04   // synchronized input, ro
  } r5p_gpio_reg_e;

endpackage: r5p_bus_pkg

// ==== hw/r5p_bus_if.sv ====
////////////////////////////////////////////////////////////
// r5p system bus interface
// request/acknowledge bus, one transfer per req & ack cycle
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface r5p_bus_if
  import r5p_bus_pkg::*;
();

  // request side
  logic     req;  // request
  logic     wen;  // write enable, 0 is read
  r5p_adr_t adr;  // byte address
  r5p_sel_t sel;  // byte select
  r5p_dat_t wdt;  // write data
  // response side
  r5p_dat_t rdt;  // read data, cycle after transfer
  logic     ack;  // acknowledge

  // requester, master or decoder output
  modport man (
    output req,
    output wen,
    output adr,
    output sel,
    output wdt,
    input  rdt,
    input  ack
  );

  // device, or decoder input
  modport sub (
    input  req,
    input  wen,
    input  adr,
    input  sel,
    input  wdt,
    output rdt,
    output ack
  );

endinterface: r5p_bus_if

// ==== hw/r5p_bus_dec.sv ====
////////////////////////////////////////////////////////////
// r5p system bus decoder
// routes one master to several devices by address pattern
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "r5p_bus_defines.svh"

module r5p_bus_dec
  import r5p_bus_pkg::*;
(
  input logic       clk,
  input logic       rst,
  r5p_bus_if.sub    bus_s,              // from master
  r5p_bus_if.man    bus_m [`R5P_BN]     // to devices
);

  // address patterns, index 0 memory, index 1 gpio
  localparam r5p_adr_t AS [`R5P_BN] = '{`R5P_MEM_AS, `R5P_GPIO_AS};

  ////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////

  logic [`R5P_BN-1:0] s_dec;  // decode of current address
  logic               s_unm;  // no pattern matched
  logic [`R5P_BN-1:0] m_dec;  // decode held from last transfer
  logic               m_unm;  // last transfer was unmapped

  logic [`R5P_BN-1:0] t_ack;  // device acks gathered
  r5p_dat_t           t_rdt [`R5P_BN];

  ////////////////////////////////////////////////////////////
  // decode and forward path
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `R5P_BN; i++) begin : g_dev
    assign s_dec[i] = bus_s.adr ==? AS[i];  // wildcard match
    // only the selected device sees req
    assign bus_m[i].req = s_dec[i] & bus_s.req;
    assign bus_m[i].wen = bus_s.wen;  // rest is broadcast
    assign bus_m[i].adr = bus_s.adr;
    assign bus_m[i].sel = bus_s.sel;
    assign bus_m[i].wdt = bus_s.wdt;
    // collect responses
    assign t_ack[i] = bus_m[i].ack;
    assign t_rdt[i] = bus_m[i].rdt;
  end

  assign s_unm = ~|s_dec;

  ////////////////////////////////////////////////////////////
  // backward path
  ////////////////////////////////////////////////////////////

  // ack from the device decoded now, unmapped acks at once
  assign bus_s.ack = |(s_dec & t_ack) | (s_unm & bus_s.req);

  // read data ORed from the device that took the transfer
  always_comb begin
    bus_s.rdt = '0;
    if (!m_unm) begin  // unmapped read gives zero
      for (int unsigned i = 0; i < `R5P_BN; i++) begin
        bus_s.rdt |= m_dec[i] ? t_rdt[i] : '0;
      end
    end
  end

  // decode copy taken at each transfer
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      m_dec <= '0;
      m_unm <= 1'b0;
    end else if (bus_s.req & bus_s.ack) begin
      m_dec <= s_dec;
      m_unm <= s_unm;
    end
  end

endmodule: r5p_bus_dec

// ==== hw/r5p_bus_mem.sv ====
////////////////////////////////////////////////////////////
// r5p bus memory device
// zero wait states, byte select writes, registered read
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "r5p_bus_defines.svh"

module r5p_bus_mem
  import r5p_bus_pkg::*;
(
  input logic    clk,
  input logic    rst,
  r5p_bus_if.sub bus
);

  localparam int unsigned SW = `R5P_DW/8;               // bytes per word
  localparam int unsigned IW = $clog2(`R5P_MEM_DEPTH);  // word index bits

  ////////////////////////////////////////////////////////////
  // storage and access decode
  ////////////////////////////////////////////////////////////

  r5p_dat_t        mem [`R5P_MEM_DEPTH];
  logic [IW-1:0]   idx;   // word index, upper bits wrap
  logic            trn;   // transfer this cycle
  logic            wtrn;  // write transfer
  logic            rtrn;  // read transfer

  assign idx  = bus.adr[IW+1:2];  // drop byte offset
  assign trn  = bus.req & bus.ack;
  assign wtrn = trn & bus.wen;
  assign rtrn = trn & ~bus.wen;

  // no wait states
  assign bus.ack = bus.req;

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wtrn) begin
      for (int unsigned b = 0; b < SW; b++) begin
        if (bus.sel[b]) begin
          mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];  // selected bytes only
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // data lands the cycle after the transfer
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bus.rdt <= '0;
    end else if (rtrn) begin
      bus.rdt <= mem[idx];
    end
  end

endmodule: r5p_bus_mem

// ==== hw/r5p_bus_gpio.sv ====
////////////////////////////////////////////////////////////
// r5p bus gpio device
// output register and synchronized input, one wait state
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "r5p_bus_defines.svh"

module r5p_bus_gpio
  import r5p_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  r5p_bus_if.sub   bus,
  output r5p_dat_t gpio_out,  // driven pins
  input  r5p_dat_t gpio_in    // asynchronous pins
);

  localparam int unsigned SW = `R5P_DW/8;

  logic       wst;      // wait state done, ack allowed
  logic       trn;      // transfer this cycle
  logic [7:0] ofs;      // register offset
  r5p_dat_t   in_meta;  // first sync stage
  r5p_dat_t   in_sync;  // second sync stage, readable

  assign ofs = bus.adr[7:0];
  assign trn = bus.req & bus.ack;

  ////////////////////////////////////////////////////////////
  // wait state
  ////////////////////////////////////////////////////////////

  // ack in the second request cycle
  assign bus.ack = bus.req & wst;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wst <= 1'b0;
    end else begin
      wst <= bus.req & ~bus.ack;  // cleared after each transfer
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  // output register, byte select writes
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      gpio_out <= '0;
    end else if (trn && bus.wen && ofs == GPIO_OUT) begin
      for (int unsigned b = 0; b < SW; b++) begin
        if (bus.sel[b]) gpio_out[8*b +: 8] <= bus.wdt[8*b +: 8];
      end
    end
  end

  // two flop input synchronizer
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_in;
      in_sync <= in_meta;
    end
  end

  // read mux, registered
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bus.rdt <= '0;
    end else if (trn && !bus.wen) begin
      case (ofs)
        GPIO_OUT: bus.rdt <= gpio_out;
        GPIO_IN:  bus.rdt <= in_sync;
        default:  bus.rdt <= '0;  // unlisted offset
      endcase
    end
  end

endmodule: r5p_bus_gpio

// ==== hw/r5p_bus_sys.sv ====
////////////////////////////////////////////////////////////
// r5p bus subsystem top
// master port through decoder to memory and gpio
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "r5p_bus_defines.svh"

module r5p_bus_sys
  import r5p_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  // master port
  input  logic     req,
  input  logic     wen,
  input  r5p_adr_t adr,
  input  r5p_sel_t sel,
  input  r5p_dat_t wdt,
  output r5p_dat_t rdt,
  output logic     ack,
  // gpio pins
  output r5p_dat_t gpio_out,
  input  r5p_dat_t gpio_in
);

  ////////////////////////////////////////////////////////////
  // buses
  ////////////////////////////////////////////////////////////

  r5p_bus_if bus_s ();             // master side
  r5p_bus_if bus_m [`R5P_BN] ();   // 0 memory, 1 gpio

  // top ports onto the master bus
  assign bus_s.req = req;
  assign bus_s.wen = wen;
  assign bus_s.adr = adr;
  assign bus_s.sel = sel;
  assign bus_s.wdt = wdt;
  assign rdt       = bus_s.rdt;
  assign ack       = bus_s.ack;

  ////////////////////////////////////////////////////////////
  // decoder and devices
  ////////////////////////////////////////////////////////////

  r5p_bus_dec i_dec (
    .clk   (clk),
    .rst   (rst),
    .bus_s (bus_s),
    .bus_m (bus_m)
  );

  r5p_bus_mem i_mem (
    .clk (clk),
    .rst (rst),
    .bus (bus_m[0])
  );

  r5p_bus_gpio i_gpio (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus_m[1]),
    .gpio_out (gpio_out),
    .gpio_in  (gpio_in)
  );

endmodule: r5p_bus_sys

// ==== verification/r5p_bus_chk.sv ====
////////////////////////////////////////////////////////////
// r5p bus subsystem checker
// compares read data, ack latency and gpio_out per row
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module r5p_bus_chk
  import r5p_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  // dut ports watched
  input  logic     req,
  input  logic     ack,
  input  r5p_dat_t rdt,
  input  r5p_dat_t gpio_out,
  // expectations from the stimulus side
  input  logic     stb,       // row done, this is the data cycle
  input  logic     rd,        // row was a read
  input  logic     no_ack,    // stimulus gave up waiting
  input  int       row,
  input  r5p_dat_t exp_rdt,
  input  r5p_dat_t exp_gout,
  input  int       exp_lat,   // request cycles up to ack
  // running counts
  output int       row_cnt,
  output int       fail_cnt
);

  int wait_cnt;  // request cycles seen so far
  int ack_lat;   // latency of the last transfer

  // compare one finished row, one line printed when it is clean
  task automatic check_row();
    bit bad;
    bad = 1'b0;
    row_cnt++;
    if (no_ack) begin
      $display("row %0d: no acknowledge within 4 cycles", row);
      bad = 1'b1;
    end else begin
      if (ack_lat != exp_lat) begin
        $display("mismatch at %0t: row %0d acknowledged after %0d cycles, expected %0d",
                 $time, row, ack_lat, exp_lat);
        bad = 1'b1;
      end
      if (rd && rdt !== exp_rdt) begin
        $display("mismatch at %0t: row %0d read data %h, expected %h",
                 $time, row, rdt, exp_rdt);
        bad = 1'b1;
      end
    end
    if (gpio_out !== exp_gout) begin
      $display("mismatch at %0t: row %0d gpio_out %h, expected %h",
               $time, row, gpio_out, exp_gout);
      bad = 1'b1;
    end
    wait_cnt = 0;  // fresh count for the next row
    if (bad) fail_cnt++;
    else $display("row %0d: %s ok", row, rd ? "read" : "write");
  endtask

  ////////////////////////////////////////////////////////////
  // sampling at the falling edge, away from the drive time
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      wait_cnt = 0;
      row_cnt  = 0;
      fail_cnt = 0;
    end else begin
      if (req) begin
        wait_cnt++;
        if (ack) begin  // transfer at the next rising edge
          ack_lat  = wait_cnt;
          wait_cnt = 0;
        end
      end
      if (stb) check_row();
    end
  end

endmodule: r5p_bus_chk

// ==== verification/r5p_bus_tb.sv ====
////////////////////////////////////////////////////////////
// r5p bus subsystem testbench
// table driven master accesses to memory and gpio
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module r5p_bus_tb
  import r5p_bus_pkg::*;
();

  localparam time CLK_P   = 40;  // clock period
  localparam time DRV_D   = 1;   // drive delay after rising edge
  localparam int  ACK_MAX = 4;   // request cycles before giving up

  // one stimulus row
  typedef struct packed {
    logic       wen;
    r5p_adr_t   adr;
    r5p_sel_t   sel;
    r5p_dat_t   wdt;
    r5p_dat_t   gin;   // gpio_in while the row runs
    r5p_dat_t   exp;   // expected read data
    r5p_dat_t   gout;  // expected gpio_out after the row
    logic [2:0] lat;   // expected cycles to ack
  } row_t;

  logic     clk, rst;
  logic     req, wen, ack;
  r5p_adr_t adr;
  r5p_sel_t sel;
  r5p_dat_t wdt, rdt;
  r5p_dat_t gpio_out, gpio_in;
  // checker link
  logic     chk_stb, chk_rd, chk_no_ack;
  int       chk_row, chk_lat;
  r5p_dat_t chk_exp, chk_gout;
  int       row_cnt, fail_cnt;

  row_t     tbl [$];
  logic     tbl_done;

  ////////////////////////////////////////////////////////////
  // dut and checker
  ////////////////////////////////////////////////////////////

  r5p_bus_sys i_r5p_bus_sys (
    .clk (clk), .rst (rst), .req (req), .wen (wen), .adr (adr), .sel (sel),
    .wdt (wdt), .rdt (rdt), .ack (ack), .gpio_out (gpio_out), .gpio_in (gpio_in)
  );

  r5p_bus_chk i_chk (
    .clk (clk), .rst (rst), .req (req), .ack (ack), .rdt (rdt), .gpio_out (gpio_out),
    .stb (chk_stb), .rd (chk_rd), .no_ack (chk_no_ack), .row (chk_row),
    .exp_rdt (chk_exp), .exp_gout (chk_gout), .exp_lat (chk_lat),
    .row_cnt (row_cnt), .fail_cnt (fail_cnt)
  );

  // 32 bit xorshift step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y ^= y << 13;
    y ^= y >> 17;
    y ^= y << 5;
    return y;
  endfunction

  task automatic add_row(input logic w, input r5p_adr_t a, input r5p_sel_t s,
                         input r5p_dat_t d, input r5p_dat_t g, input r5p_dat_t e,
                         input r5p_dat_t o, input int l);
    row_t r;
    r = '{wen: w, adr: a, sel: s, wdt: d, gin: g, exp: e, gout: o, lat: l[2:0]};
    tbl.push_back(r);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] x;
    // memory full word, then byte select merges
    add_row(1, 32'h0000_0010, 4'hf, 32'h1122_3344, '0, '0, '0, 1);
    add_row(0, 32'h0000_0010, 4'hf, '0, '0, 32'h1122_3344, '0, 1);
    add_row(1, 32'h0000_0010, 4'h5, 32'haabb_ccdd, '0, '0, '0, 1);
    add_row(0, 32'h0000_0010, 4'hf, '0, '0, 32'h11bb_33dd, '0, 1);
    add_row(1, 32'h0000_0010, 4'ha, 32'h5566_7788, '0, '0, '0, 1);
    add_row(0, 32'h0000_0010, 4'hf, '0, '0, 32'h55bb_77dd, '0, 1);
    // gpio output register, one wait state
    add_row(1, 32'h0001_0000, 4'hf, 32'hcafe_f00d, '0, '0, 32'hcafe_f00d, 2);
    add_row(0, 32'h0001_0000, 4'hf, '0, '0, 32'hcafe_f00d, 32'hcafe_f00d, 2);
    add_row(1, 32'h0001_0000, 4'h3, 32'h0000_1234, '0, '0, 32'hcafe_1234, 2);
    // gpio input held over two rows for the synchronizer
    add_row(0, 32'h0001_0000, 4'hf, '0, 32'ha5a5_5a5a, 32'hcafe_1234, 32'hcafe_1234, 2);
    add_row(0, 32'h0001_0004, 4'hf, '0, 32'ha5a5_5a5a, 32'ha5a5_5a5a, 32'hcafe_1234, 2);
    // unmapped and unlisted, input pins still nonzero for the unlisted read
    add_row(0, 32'h0002_0000, 4'hf, '0, 32'ha5a5_5a5a, '0, 32'hcafe_1234, 1);
    add_row(0, 32'h0001_0008, 4'hf, '0, 32'ha5a5_5a5a, '0, 32'hcafe_1234, 2);
    add_row(1, 32'h0002_0010, 4'hf, 32'hffff_ffff, '0, '0, 32'hcafe_1234, 1);
    add_row(1, 32'h0001_0008, 4'hf, 32'hdead_beef, '0, '0, 32'hcafe_1234, 2);
    add_row(0, 32'h0001_0000, 4'hf, '0, '0, 32'hcafe_1234, 32'hcafe_1234, 2);
    // device switching, then memory wrap alias
    add_row(0, 32'h0000_0010, 4'hf, '0, '0, 32'h55bb_77dd, 32'hcafe_1234, 1);
    add_row(0, 32'h0001_0000, 4'hf, '0, '0, 32'hcafe_1234, 32'hcafe_1234, 2);
    add_row(0, 32'h0000_0010, 4'hf, '0, '0, 32'h55bb_77dd, 32'hcafe_1234, 1);
    add_row(0, 32'h0000_0410, 4'hf, '0, '0, 32'h55bb_77dd, 32'hcafe_1234, 1);
    // random words, replayed from the same seed for the reads
    x = 32'd18;
    for (int k = 0; k < 4; k++) begin
      x = xorshift(x);
      add_row(1, 32'h0000_0100 + 4*k, 4'hf, x, '0, '0, 32'hcafe_1234, 1);
    end
    x = 32'd18;
    for (int k = 0; k < 4; k++) begin
      x = xorshift(x);
      add_row(0, 32'h0000_0100 + 4*k, 4'hf, '0, '0, x, 32'hcafe_1234, 1);
    end
  endtask

  // one request, held until ack, then one idle data cycle
  task automatic run_row(input int n);
    row_t r;
    int   cnt;
    logic got;
    r       = tbl[n];
    req     = 1'b1;
    wen     = r.wen;
    adr     = r.adr;
    sel     = r.sel;
    wdt     = r.wdt;
    gpio_in = r.gin;
    cnt     = 0;
    got     = 1'b0;
    while (!got && cnt < ACK_MAX) begin
      @(negedge clk);
      cnt++;
      got = ack;
    end
    @(posedge clk);
    #DRV_D;
    req        = 1'b0;
    // next address already on the bus, read data must follow the held decode
    if (n + 1 < tbl.size()) adr = tbl[n+1].adr;
    chk_stb    = 1'b1;  // checker looks at the falling edge
    chk_rd     = !r.wen;
    chk_no_ack = !got;
    chk_row    = n;
    chk_exp    = r.exp;
    chk_gout   = r.gout;
    chk_lat    = r.lat;
    @(posedge clk);
    #DRV_D;
    chk_stb = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // clock, main sequence, watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_P/2) clk = ~clk;
  end

  initial begin
    rst        = 1'b1;
    req        = 1'b0;
    wen        = 1'b0;
    adr        = '0;
    sel        = '0;
    wdt        = '0;
    gpio_in    = '0;
    chk_stb    = 1'b0;
    chk_rd     = 1'b0;
    chk_no_ack = 1'b0;
    chk_row    = 0;
    chk_lat    = 0;
    chk_exp    = '0;
    chk_gout   = '0;
    tbl_done   = 1'b0;
    build_table();
    tbl_done = 1'b1;
    repeat (5) @(posedge clk);
    #DRV_D rst = 1'b0;
    for (int n = 0; n < tbl.size(); n++) run_row(n);
    @(posedge clk);
    $display("summary: %0d of %0d rows checked, %0d failed", row_cnt, tbl.size(), fail_cnt);
    if (fail_cnt == 0 && row_cnt == tbl.size()) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    wait (tbl_done === 1'b1);
    #(CLK_P * (tbl.size() * 6 + 20));
    $display("watchdog: run did not finish within %0d clock periods", tbl.size() * 6 + 20);
    $display("*** FAILED ***");
    $finish;
  end

endmodule: r5p_bus_tb

// ==== list.f ====
+incdir+include
hw/r5p_bus_pkg.sv
hw/r5p_bus_if.sv
hw/r5p_bus_dec.sv
hw/r5p_bus_mem.sv
hw/r5p_bus_gpio.sv
hw/r5p_bus_sys.sv
verification/r5p_bus_chk.sv
verification/r5p_bus_tb.sv

// ==== Bender.yml ====
package:
  name: r5p_bus

export_include_dirs:
  - include

sources:
  # design, compile order
  - include_dirs:
      - include
    files:
      - hw/r5p_bus_pkg.sv
      - hw/r5p_bus_if.sv
      - hw/r5p_bus_dec.sv
      - hw/r5p_bus_mem.sv
      - hw/r5p_bus_gpio.sv
      - hw/r5p_bus_sys.sv
  # testbench
  - target: simulation
    files:
      - verification/r5p_bus_chk.sv
      - verification/r5p_bus_tb.sv
